// File: design/lawnPkg.sv
`default_nettype none

package lawnPkg;

	// Screen and lawn geometry, all in pixels
	localparam int CoordWidth = 10;
	localparam int ColorWidth = 12;
	localparam int NumRows = 5;
	localparam int NumCols = 5;
	localparam int NumKinds = 3;
	localparam int LawnTop = 160;
	localparam int RowHeight = 87;
	localparam int LawnLeft = 300;
	localparam int ColumnWidth = 100;
	localparam int MenuIconHalf = 20;
	localparam int MenuIconY = 80;
	localparam int PlantHalf = 20;
	localparam int OutlineWidth = 2;
	localparam int BodyHalfWidth = 8;
	localparam int BodyMargin = 10;

	// Zombie positions are held in CoordWidth bits
	localparam logic [CoordWidth-1:0] StartX = 10'd799;
	localparam logic [CoordWidth-1:0] EndOfLawn = 10'd124;

	localparam int ShotSteps = 8;
	localparam int HitsToKill = 5;

	// A zombie waits until its leader has walked past the entry column or has died
	// The value -1 marks a zombie that walks in right away
	localparam int ZombieLeader [NumRows] = '{1, -1, 0, 0, 3};
	localparam int ZombieEntryX [NumRows] = '{600, 0, 600, 700, 700};

	localparam logic [ColorWidth-1:0] Black = 12'b0000_0000_0000;
	localparam logic [ColorWidth-1:0] Grey = 12'b0000_1011_0100;
	localparam logic [ColorWidth-1:0] Green = 12'b0000_1111_0000;
	localparam logic [ColorWidth-1:0] DarkGreen = 12'b0011_1001_0010;
	localparam logic [ColorWidth-1:0] Red = 12'b1111_0000_0000;
	localparam logic [ColorWidth-1:0] ZombieSkin = 12'b1010_1010_1011;
	localparam logic [ColorWidth-1:0] PeaGreen = 12'b0000_1010_0000;
	localparam logic [ColorWidth-1:0] Yellow = 12'b1111_1111_0000;
	localparam logic [ColorWidth-1:0] Brown = 12'b1000_0100_0000;

	typedef enum logic [1:0] {None, Peashooter, Sunflower, Walnut} PlantKindT;
	typedef enum logic [1:0] {Idle, Menu, Lawn} CursorModeT;
	typedef enum logic [1:0] {Playing, Won, Lost} GameStateT;

	// Tile index is row * NumCols + column
	typedef PlantKindT [NumRows*NumCols-1:0] PlantMapT;

endpackage

`default_nettype wire

// File: design/lawnIfs.sv
`default_nettype none

// Cursor position and the selected plant kind, shared by input and output sides
interface lawnCursorIf;
	lawnPkg::CursorModeT mode;
	logic [1:0] menuSlot;
	logic [2:0] row;
	logic [2:0] column;
	lawnPkg::PlantKindT kind;
	logic placeStrobe;

	modport driver (output mode, output menuSlot, output row, output column,
		output kind, output placeStrobe);
	modport grid (input row, input column, input kind, input placeStrobe);
	modport view (input mode, input menuSlot, input row, input column);
endinterface

// Zombie positions and game state as seen by the renderer
interface zombieViewIf;
	logic [lawnPkg::NumRows-1:0][lawnPkg::CoordWidth-1:0] zombieX;
	logic [lawnPkg::NumRows-1:0] zombieAlive;
	lawnPkg::GameStateT state;

	modport driver (output zombieX, output zombieAlive, output state);
	modport view (input zombieX, input zombieAlive, input state);
endinterface

`default_nettype wire

// File: design/plantCursor.sv
`default_nettype none

module plantCursor (
	input logic clk,
	input logic rst,
	input logic selectButton,
	input logic leftButton,
	input logic rightButton,
	input logic upButton,
	input logic downButton,
	lawnCursorIf.driver cur
);

	// One action per cycle, select has priority over the arrows
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cur.mode <= lawnPkg::Idle;
			cur.menuSlot <= 2'd0;
			cur.row <= 3'd0;
			cur.column <= 3'd0;
			cur.kind <= lawnPkg::None;
			cur.placeStrobe <= 1'b0;
		end
		else
		begin
			cur.placeStrobe <= 1'b0;
			case (cur.mode)
				lawnPkg::Idle:
				begin
					if (selectButton)
					begin
						cur.mode <= lawnPkg::Menu;
						cur.menuSlot <= 2'd0;
					end
				end
				lawnPkg::Menu:
				begin
					if (selectButton)
					begin
						case (cur.menuSlot)
							2'd0: cur.kind <= lawnPkg::Peashooter;
							2'd1: cur.kind <= lawnPkg::Sunflower;
							default: cur.kind <= lawnPkg::Walnut;
						endcase
						cur.mode <= lawnPkg::Lawn;
						cur.row <= 3'd0;
						cur.column <= 3'd0;
					end
					else if (leftButton && cur.menuSlot != 2'd0)
						cur.menuSlot <= cur.menuSlot - 2'd1;
					else if (rightButton && int'(cur.menuSlot) < lawnPkg::NumKinds - 1)
						cur.menuSlot <= cur.menuSlot + 2'd1;
				end
				lawnPkg::Lawn:
				begin
					// Row and column hold still so the grid writes the chosen tile
					if (selectButton)
					begin
						cur.placeStrobe <= 1'b1;
						cur.mode <= lawnPkg::Idle;
					end
					else if (leftButton && cur.column != 3'd0)
						cur.column <= cur.column - 3'd1;
					else if (rightButton && int'(cur.column) < lawnPkg::NumCols - 1)
						cur.column <= cur.column + 3'd1;
					else if (upButton && cur.row != 3'd0)
						cur.row <= cur.row - 3'd1;
					else if (downButton && int'(cur.row) < lawnPkg::NumRows - 1)
						cur.row <= cur.row + 3'd1;
				end
				default:
					cur.mode <= lawnPkg::Idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/plantGrid.sv
`default_nettype none

module plantGrid (
	input logic clk,
	input logic rst,
	lawnCursorIf.grid cur,
	output lawnPkg::PlantMapT plants,
	output logic [lawnPkg::NumRows-1:0] rowHasShooter
);

	logic [4:0] tileIndex;

	assign tileIndex = 5'(int'(cur.row) * lawnPkg::NumCols + int'(cur.column));

	// An occupied tile keeps its first plant
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < lawnPkg::NumRows * lawnPkg::NumCols; i++)
				plants[i] <= lawnPkg::None;
		end
		else if (cur.placeStrobe && plants[tileIndex] == lawnPkg::None)
			plants[tileIndex] <= cur.kind;
	end

	// A row is defended as soon as any of its tiles holds a peashooter
	always_comb
	begin
		rowHasShooter = '0;
		for (int r = 0; r < lawnPkg::NumRows; r++)
		begin
			for (int c = 0; c < lawnPkg::NumCols; c++)
			begin
				if (plants[r * lawnPkg::NumCols + c] == lawnPkg::Peashooter)
					rowHasShooter[r] = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/zombieWave.sv
`default_nettype none

module zombieWave #(
	parameter int StepCycles = 500000
) (
	input logic clk,
	input logic rst,
	input logic [lawnPkg::NumRows-1:0] rowHasShooter,
	zombieViewIf.driver view,
	output logic [15:0] killCount,
	output logic gameWon,
	output logic gameLost
);

	logic [$clog2(StepCycles)-1:0] stepCount;
	logic [$clog2(lawnPkg::ShotSteps)-1:0] shotCount;
	logic stepTick;
	logic shotTick;
	logic [lawnPkg::NumRows-1:0][lawnPkg::CoordWidth-1:0] zombieX;
	logic [lawnPkg::NumRows-1:0][lawnPkg::CoordWidth-1:0] nextX;
	logic [lawnPkg::NumRows-1:0] alive;
	logic [lawnPkg::NumRows-1:0] nextAlive;
	logic [lawnPkg::NumRows-1:0][2:0] hits;
	logic [lawnPkg::NumRows-1:0][2:0] nextHits;
	logic [2:0] killsNow;
	logic reachedEnd;
	lawnPkg::GameStateT state;

	assign stepTick = int'(stepCount) == StepCycles - 1;
	assign shotTick = stepTick && int'(shotCount) == lawnPkg::ShotSteps - 1;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			stepCount <= '0;
			shotCount <= '0;
		end
		else if (stepTick)
		begin
			stepCount <= '0;
			shotCount <= shotTick ? '0 : shotCount + 1'b1;
		end
		else
			stepCount <= stepCount + 1'b1;
	end

	// Movement and hits for one step, taken from the positions before the step
	always_comb
	begin
		int lead;
		logic canMove;
		nextX = zombieX;
		nextAlive = alive;
		nextHits = hits;
		killsNow = 3'd0;
		reachedEnd = 1'b0;
		for (int i = 0; i < lawnPkg::NumRows; i++)
		begin
			lead = (lawnPkg::ZombieLeader[i] < 0) ? 0 : lawnPkg::ZombieLeader[i];
			canMove = lawnPkg::ZombieLeader[i] < 0 || !alive[lead]
				|| int'(zombieX[lead]) <= lawnPkg::ZombieEntryX[i];
			if (alive[i] && canMove)
				nextX[i] = zombieX[i] - 1'b1;
			if (shotTick && alive[i] && rowHasShooter[i] && zombieX[i] < lawnPkg::StartX)
			begin
				nextHits[i] = hits[i] + 3'd1;
				if (int'(hits[i]) + 1 == lawnPkg::HitsToKill)
				begin
					nextAlive[i] = 1'b0;
					killsNow = killsNow + 3'd1;
				end
			end
			if (nextAlive[i] && nextX[i] <= lawnPkg::EndOfLawn)
				reachedEnd = 1'b1;
		end
	end

	// Everything freezes once the game is decided
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < lawnPkg::NumRows; i++)
				zombieX[i] <= lawnPkg::StartX;
			alive <= '1;
			hits <= '0;
			killCount <= 16'd0;
			state <= lawnPkg::Playing;
		end
		else if (state == lawnPkg::Playing && stepTick)
		begin
			zombieX <= nextX;
			alive <= nextAlive;
			hits <= nextHits;
			killCount <= killCount + 16'(killsNow);
			if (reachedEnd)
				state <= lawnPkg::Lost;
			else if (nextAlive == '0)
				state <= lawnPkg::Won;
		end
	end

	assign view.zombieX = zombieX;
	assign view.zombieAlive = alive;
	assign view.state = state;
	assign gameWon = state == lawnPkg::Won;
	assign gameLost = state == lawnPkg::Lost;

endmodule

`default_nettype wire

// File: design/lawnRenderer.sv
`default_nettype none

module lawnRenderer (
	input logic clk,
	input logic rst,
	input logic bright,
	input logic [lawnPkg::CoordWidth-1:0] hCount,
	input logic [lawnPkg::CoordWidth-1:0] vCount,
	lawnCursorIf.view cur,
	zombieViewIf.view zv,
	input lawnPkg::PlantMapT plants,
	output logic [lawnPkg::ColorWidth-1:0] rgb
);

	logic [lawnPkg::ColorWidth-1:0] pixelColor;

	function automatic int absDiff(input int a, input int b);
		return (a > b) ? a - b : b - a;
	endfunction

	// True on the inner OutlineWidth band of a box
	function automatic logic onBorder(input int x, input int y, input int left,
		input int top, input int width, input int height);
		logic inBox;
		inBox = x >= left && x < left + width && y >= top && y < top + height;
		return inBox && (x < left + lawnPkg::OutlineWidth
			|| x >= left + width - lawnPkg::OutlineWidth
			|| y < top + lawnPkg::OutlineWidth
			|| y >= top + height - lawnPkg::OutlineWidth);
	endfunction

	function automatic logic [lawnPkg::ColorWidth-1:0] kindColor(input lawnPkg::PlantKindT kind);
		case (kind)
			lawnPkg::Peashooter: return lawnPkg::PeaGreen;
			lawnPkg::Sunflower: return lawnPkg::Yellow;
			lawnPkg::Walnut: return lawnPkg::Brown;
			default: return lawnPkg::Green;
		endcase
	endfunction

	always_comb
	begin
		int x;
		int y;
		int pixRow;
		int pixCol;
		int rowTop;
		int colLeft;
		logic inLawn;
		logic cursorHit;
		logic zombieHit;
		logic plantHit;
		logic [lawnPkg::ColorWidth-1:0] iconColor;
		lawnPkg::PlantKindT tileKind;
		x = int'(hCount);
		y = int'(vCount);
		inLawn = y >= lawnPkg::LawnTop && x >= lawnPkg::LawnLeft
			&& y < lawnPkg::LawnTop + lawnPkg::NumRows * lawnPkg::RowHeight
			&& x < lawnPkg::LawnLeft + lawnPkg::NumCols * lawnPkg::ColumnWidth;
		pixRow = 0;
		pixCol = 0;
		for (int r = 1; r < lawnPkg::NumRows; r++)
			if (y >= lawnPkg::LawnTop + r * lawnPkg::RowHeight)
				pixRow = r;
		for (int c = 1; c < lawnPkg::NumCols; c++)
			if (x >= lawnPkg::LawnLeft + c * lawnPkg::ColumnWidth)
				pixCol = c;
		rowTop = lawnPkg::LawnTop + pixRow * lawnPkg::RowHeight;
		colLeft = lawnPkg::LawnLeft + pixCol * lawnPkg::ColumnWidth;
		tileKind = plants[pixRow * lawnPkg::NumCols + pixCol];

		// The cursor disappears once the game is decided
		cursorHit = 1'b0;
		if (zv.state == lawnPkg::Playing && cur.mode == lawnPkg::Menu)
			cursorHit = onBorder(x, y, int'(cur.menuSlot) * lawnPkg::ColumnWidth, 0,
				lawnPkg::ColumnWidth, lawnPkg::LawnTop);
		else if (zv.state == lawnPkg::Playing && cur.mode == lawnPkg::Lawn)
			cursorHit = onBorder(x, y,
				lawnPkg::LawnLeft + int'(cur.column) * lawnPkg::ColumnWidth,
				lawnPkg::LawnTop + int'(cur.row) * lawnPkg::RowHeight,
				lawnPkg::ColumnWidth, lawnPkg::RowHeight);

		// Zombie i walks along lawn row i
		zombieHit = 1'b0;
		for (int i = 0; i < lawnPkg::NumRows; i++)
			if (zv.zombieAlive[i]
				&& absDiff(x, int'(zv.zombieX[i])) <= lawnPkg::BodyHalfWidth
				&& y >= lawnPkg::LawnTop + i * lawnPkg::RowHeight + lawnPkg::BodyMargin
				&& y < lawnPkg::LawnTop + (i + 1) * lawnPkg::RowHeight - lawnPkg::BodyMargin)
				zombieHit = 1'b1;

		plantHit = inLawn && tileKind != lawnPkg::None
			&& absDiff(x, colLeft + lawnPkg::ColumnWidth / 2) <= lawnPkg::PlantHalf
			&& absDiff(y, rowTop + lawnPkg::RowHeight / 2) <= lawnPkg::PlantHalf;

		// Menu slot s shows kind s + 1
		iconColor = lawnPkg::Grey;
		for (int s = 0; s < lawnPkg::NumKinds; s++)
			if (absDiff(x, s * lawnPkg::ColumnWidth + lawnPkg::ColumnWidth / 2)
				<= lawnPkg::MenuIconHalf
				&& absDiff(y, lawnPkg::MenuIconY) <= lawnPkg::MenuIconHalf)
				iconColor = kindColor(lawnPkg::PlantKindT'(s + 1));

		if (!bright)
			pixelColor = lawnPkg::Black;
		else if (cursorHit)
			pixelColor = lawnPkg::Red;
		else if (zombieHit)
			pixelColor = lawnPkg::ZombieSkin;
		else if (plantHit)
			pixelColor = kindColor(tileKind);
		else if (y < lawnPkg::LawnTop)
			pixelColor = iconColor;
		else if (inLawn && (pixRow + pixCol) % 2 == 1)
			pixelColor = lawnPkg::DarkGreen;
		else
			pixelColor = lawnPkg::Green;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			rgb <= lawnPkg::Black;
		else
			rgb <= pixelColor;
	end

endmodule

`default_nettype wire

// File: design/lawnGame.sv
`default_nettype none

module lawnGame #(
	parameter int StepCycles = 500000
) (
	input logic clk,
	input logic rst,
	input logic bright,
	input logic [lawnPkg::CoordWidth-1:0] hCount,
	input logic [lawnPkg::CoordWidth-1:0] vCount,
	input logic selectButton,
	input logic leftButton,
	input logic rightButton,
	input logic upButton,
	input logic downButton,
	output logic [lawnPkg::ColorWidth-1:0] rgb,
	output logic [15:0] killCount,
	output logic gameWon,
	output logic gameLost
);

	lawnCursorIf cursorBus ();
	zombieViewIf zombieBus ();

	lawnPkg::PlantMapT plants;
	logic [lawnPkg::NumRows-1:0] rowHasShooter;

	plantCursor i_plantCursor (
		.clk(clk),
		.rst(rst),
		.selectButton(selectButton),
		.leftButton(leftButton),
		.rightButton(rightButton),
		.upButton(upButton),
		.downButton(downButton),
		.cur(cursorBus.driver)
	);

	plantGrid i_plantGrid (
		.clk(clk),
		.rst(rst),
		.cur(cursorBus.grid),
		.plants(plants),
		.rowHasShooter(rowHasShooter)
	);

	zombieWave #(
		.StepCycles(StepCycles)
	) i_zombieWave (
		.clk(clk),
		.rst(rst),
		.rowHasShooter(rowHasShooter),
		.view(zombieBus.driver),
		.killCount(killCount),
		.gameWon(gameWon),
		.gameLost(gameLost)
	);

	lawnRenderer i_lawnRenderer (
		.clk(clk),
		.rst(rst),
		.bright(bright),
		.hCount(hCount),
		.vCount(vCount),
		.cur(cursorBus.view),
		.zv(zombieBus.view),
		.plants(plants),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

// File: sim/lawnGame_properties.sv
`default_nettype none

module lawnGameProperties (
	input logic clk,
	input logic rst,
	input logic bright,
	input logic [lawnPkg::ColorWidth-1:0] rgb,
	input logic [15:0] killCount,
	input logic gameWon,
	input logic gameLost
);

	int failCount = 0;

	// Won and Lost are separate end states of the wave
	wonLostExclusive: assert property (@(posedge clk) disable iff (rst) !(gameWon && gameLost))
	else
	begin
		$error("gameWon and gameLost are high together");
		failCount++;
	end

	killsNeverDrop: assert property (@(posedge clk) disable iff (rst)
		!$past(rst) |-> killCount >= $past(killCount))
	else
	begin
		$error("killCount decreased");
		failCount++;
	end

	// Only five zombies exist
	killsBounded: assert property (@(posedge clk) disable iff (rst)
		killCount <= 16'(lawnPkg::NumRows))
	else
	begin
		$error("killCount exceeds the number of zombies");
		failCount++;
	end

	blankIsBlack: assert property (@(posedge clk) disable iff (rst)
		!bright |=> rgb == lawnPkg::Black)
	else
	begin
		$error("rgb is not black one cycle after bright went low");
		failCount++;
	end

endmodule

bind lawnGame lawnGameProperties i_lawnGameProperties (
	.clk(clk),
	.rst(rst),
	.bright(bright),
	.rgb(rgb),
	.killCount(killCount),
	.gameWon(gameWon),
	.gameLost(gameLost)
);

`default_nettype wire

// File: sim/lawnChecker.sv
`default_nettype none

module lawnChecker (
	input logic clk,
	input logic [lawnPkg::ColorWidth-1:0] rgb,
	input logic [15:0] killCount,
	input logic gameWon,
	input logic gameLost
);

	int testCount = 0;
	int failedTests = 0;
	int errorCount = 0;
	int errorsAtLastTest = 0;

	task automatic compareValue(input string name, input string what,
		input logic [15:0] expected, input logic [15:0] actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s: %s expected 0x%0h, actual 0x%0h",
				name, what, expected, actual);
			errorCount++;
		end
	endtask

	task automatic finishTest(input string name);
		testCount++;
		if (errorCount != errorsAtLastTest)
		begin
			failedTests++;
			$display("[%0t] %s: failed", $time, name);
		end
		else
			$display("[%0t] %s: ok", $time, name);
		errorsAtLastTest = errorCount;
	endtask

	task automatic checkRgb(input string name, input logic [lawnPkg::ColorWidth-1:0] expected);
		compareValue(name, "rgb", 16'(expected), 16'(rgb));
		finishTest(name);
	endtask

	// Playing means neither level output is high
	function automatic logic stateReached(input lawnPkg::GameStateT level);
		case (level)
			lawnPkg::Won: return gameWon;
			lawnPkg::Lost: return gameLost;
			default: return !gameWon && !gameLost;
		endcase
	endfunction

	task automatic awaitState(input string name, input lawnPkg::GameStateT level,
		input int bound, input logic [15:0] kills);
		int waited;
		waited = 0;
		while (!stateReached(level) && waited < bound)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (!stateReached(level))
		begin
			$display("%s: the game did not reach the expected state within %0d cycles",
				name, bound);
			errorCount++;
		end
		else
		begin
			compareValue(name, "killCount", kills, killCount);
			compareValue(name, "gameWon", 16'(level == lawnPkg::Won), 16'(gameWon));
			compareValue(name, "gameLost", 16'(level == lawnPkg::Lost), 16'(gameLost));
		end
		finishTest(name);
	endtask

	task automatic printSummary(input int assertionFailures);
		$display("Summary: %0d tests, %0d failed, %0d mismatches, %0d assertion failures",
			testCount, failedTests, errorCount, assertionFailures);
	endtask

endmodule

`default_nettype wire

// File: sim/lawnGameTb.sv
`default_nettype none

module lawnGameTb;

	localparam int StepCycles = 4;
	localparam int ClockPeriod = 8;
	// Longest wait is zombie 1 walking from StartX to EndOfLawn, plus slack
	localparam int MaxWait =
		(int'(lawnPkg::StartX) - int'(lawnPkg::EndOfLawn) + 2) * StepCycles;
	localparam int SelectKey = 0;
	localparam int LeftKey = 1;
	localparam int RightKey = 2;
	localparam int UpKey = 3;
	localparam int DownKey = 4;
	localparam int RowOneMid = lawnPkg::LawnTop + lawnPkg::RowHeight + lawnPkg::RowHeight / 2;

	typedef enum logic [2:0] {DoReset, DoPress, DoProbe, DoProbeZombie, DoWait} StepKindT;

	typedef struct packed {
		StepKindT kind;
		logic [2:0] button;
		logic lit;
		logic [9:0] h;
		logic [9:0] v;
		logic [11:0] expectedRgb;
		lawnPkg::GameStateT level;
		logic [15:0] expectedKills;
		logic [15:0] bound;
	} StepT;

	logic clk;
	logic rst;
	logic bright;
	logic [lawnPkg::CoordWidth-1:0] hCount;
	logic [lawnPkg::CoordWidth-1:0] vCount;
	logic [4:0] buttons;
	logic [lawnPkg::ColorWidth-1:0] rgb;
	logic [15:0] killCount;
	logic gameWon;
	logic gameLost;
	int edgesSinceReset;
	int watchdogCycles;
	StepT steps[$];
	string stepNames[$];

	lawnGame #(
		.StepCycles(StepCycles)
	) i_lawnGame (
		.clk(clk),
		.rst(rst),
		.bright(bright),
		.hCount(hCount),
		.vCount(vCount),
		.selectButton(buttons[SelectKey]),
		.leftButton(buttons[LeftKey]),
		.rightButton(buttons[RightKey]),
		.upButton(buttons[UpKey]),
		.downButton(buttons[DownKey]),
		.rgb(rgb),
		.killCount(killCount),
		.gameWon(gameWon),
		.gameLost(gameLost)
	);

	lawnChecker i_lawnChecker (
		.clk(clk),
		.rgb(rgb),
		.killCount(killCount),
		.gameWon(gameWon),
		.gameLost(gameLost)
	);

	initial
	begin
		clk = 1'b0;
		forever #(ClockPeriod / 2) clk = ~clk;
	end

	// Rising edges since reset was released, which fixes where zombie 1 stands
	always @(posedge clk)
	begin
		if (rst)
			edgesSinceReset <= 0;
		else
			edgesSinceReset <= edgesSinceReset + 1;
	end

	function automatic void storeStep(input StepT s, input string name);
		steps.push_back(s);
		stepNames.push_back(name);
	endfunction

	function automatic void restart();
		StepT s;
		s = '0;
		s.kind = DoReset;
		storeStep(s, "reset");
	endfunction

	function automatic void press(input int key);
		StepT s;
		s = '0;
		s.kind = DoPress;
		s.button = 3'(key);
		storeStep(s, "press");
	endfunction

	function automatic void probe(input string name, input logic lit, input int h, input int v,
		input logic [11:0] expected);
		StepT s;
		s = '0;
		s.kind = DoProbe;
		s.lit = lit;
		s.h = 10'(h);
		s.v = 10'(v);
		s.expectedRgb = expected;
		storeStep(s, name);
	endfunction

	// The column is worked out when the entry runs
	function automatic void probeZombie(input string name, input int v);
		StepT s;
		s = '0;
		s.kind = DoProbeZombie;
		s.lit = 1'b1;
		s.v = 10'(v);
		s.expectedRgb = lawnPkg::ZombieSkin;
		storeStep(s, name);
	endfunction

	function automatic void expectState(input string name, input lawnPkg::GameStateT level,
		input logic [15:0] kills, input int bound);
		StepT s;
		s = '0;
		s.kind = DoWait;
		s.level = level;
		s.expectedKills = kills;
		s.bound = 16'(bound);
		storeStep(s, name);
	endfunction

	function automatic void buildTable();
		restart();
		expectState("reset state", lawnPkg::Playing, 16'd0, 0);
		probe("blanked pixel", 1'b0, 100, 100, lawnPkg::Black);
		probe("menu strip", 1'b1, 50, 10, lawnPkg::Grey);
		probe("tile 0,0", 1'b1, 320, 180, lawnPkg::Green);
		probe("tile 0,1", 1'b1, 420, 180, lawnPkg::DarkGreen);
		// Sunflower goes to row 1, column 2
		press(SelectKey);
		probe("menu cursor", 1'b1, 0, 80, lawnPkg::Red);
		press(RightKey);
		press(SelectKey);
		press(RightKey);
		press(RightKey);
		press(DownKey);
		press(SelectKey);
		probe("sunflower planted", 1'b1, 550, RowOneMid, lawnPkg::Yellow);
		// A walnut on the occupied tile is refused
		press(SelectKey);
		press(RightKey);
		press(RightKey);
		press(SelectKey);
		press(RightKey);
		press(RightKey);
		press(DownKey);
		press(SelectKey);
		probe("walnut refused", 1'b1, 550, RowOneMid, lawnPkg::Yellow);
		probeZombie("zombie 1 body", RowOneMid);
		expectState("zombies reach the house", lawnPkg::Lost, 16'd0, MaxWait);
		restart();
		expectState("restart state", lawnPkg::Playing, 16'd0, 0);
		// One peashooter in column 0 of every row
		for (int r = 0; r < lawnPkg::NumRows; r++)
		begin
			press(SelectKey);
			press(SelectKey);
			repeat (r) press(DownKey);
			press(SelectKey);
		end
		expectState("all zombies killed", lawnPkg::Won, 16'd5, MaxWait);
		// Zombie 1 dies on its fifth shot after 40 steps, close to x 759
		probe("killed zombie gone", 1'b1, 759, RowOneMid, lawnPkg::DarkGreen);
	endfunction

	task automatic resetDut();
		rst = 1'b1;
		buttons = '0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
	endtask

	task automatic driveButton(input int key);
		buttons[key] = 1'b1;
		@(posedge clk);
		#1;
		buttons = '0;
	endtask

	// Two edges let a tile written in the previous cycle reach the colour register
	task automatic samplePixel(input string name, input logic lit, input logic [9:0] h,
		input logic [9:0] v, input logic [11:0] expected);
		bright = lit;
		hCount = h;
		vCount = v;
		repeat (2) @(posedge clk);
		#1;
		i_lawnChecker.checkRgb(name, expected);
		bright = 1'b1;
	endtask

	initial
	begin
		int predictedX;
		rst = 1'b1;
		bright = 1'b1;
		hCount = '0;
		vCount = '0;
		buttons = '0;
		buildTable();
		watchdogCycles = steps.size() * MaxWait;
		for (int i = 0; i < steps.size(); i++)
		begin
			case (steps[i].kind)
				DoReset:
					resetDut();
				DoPress:
					driveButton(int'(steps[i].button));
				DoProbe:
					samplePixel(stepNames[i], steps[i].lit, steps[i].h, steps[i].v,
						steps[i].expectedRgb);
				DoProbeZombie:
				begin
					// Zombie 1 has no leader, so it steps once every StepCycles edges
					predictedX = int'(lawnPkg::StartX) - (edgesSinceReset + 1) / StepCycles;
					samplePixel(stepNames[i], 1'b1, 10'(predictedX), steps[i].v,
						steps[i].expectedRgb);
				end
				default:
					i_lawnChecker.awaitState(stepNames[i], steps[i].level,
						int'(steps[i].bound), steps[i].expectedKills);
			endcase
		end
		i_lawnChecker.printSummary(i_lawnGame.i_lawnGameProperties.failCount);
		if (i_lawnChecker.errorCount == 0 && i_lawnGame.i_lawnGameProperties.failCount == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin
		#1;
		#(longint'(watchdogCycles) * ClockPeriod);
		$display("Timeout: the run did not finish within %0d cycles", watchdogCycles);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
design/lawnPkg.sv
design/lawnIfs.sv
design/plantCursor.sv
design/plantGrid.sv
design/zombieWave.sv
design/lawnRenderer.sv
design/lawnGame.sv
sim/lawnGame_properties.sv
sim/lawnChecker.sv
sim/lawnGameTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= lawnGameTb
FILELIST ?= build.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
RUN_ARGS ?= +verilator+error+limit+1000
PASS_TEXT = PASS: all tests
FAIL_TEXT = FAIL: see errors above

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	-$(BUILD_DIR)/$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG) || ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
